// File: trace_consts.svh
`ifndef TRACE_CONSTS_SVH
`define TRACE_CONSTS_SVH

// width of the full instruction word captured as it leaves decode.
`define TRC_INSTR_W 32

// per-instruction stall counters saturate at their all-ones value.
`define TRC_STALL_W 8

// the free-running cycle stamp restarts at zero on reset.
`define TRC_CYCLE_W 32

// retire sequence number.
`define TRC_SEQ_W 16

// whole-run stall and flush totals saturate at their maximum.
`define TRC_TOTAL_W 16

`endif

// File: pipe_trace_pkg.sv
`include "trace_consts.svh"

package pipe_trace_pkg;

    // raw instruction word as seen in decode.
    typedef logic [`TRC_INSTR_W-1:0] instr_word_t;

    // saturating per-instruction stall count.
    typedef logic [`TRC_STALL_W-1:0] stall_cnt_t;

    // one in-flight instruction as it moves through the five slots.
    // instr stays zero until the token leaves decode, and stays zero for
    // a flushed token.
    typedef struct packed {
        instr_word_t instr;
        stall_cnt_t  fetch_stalls;  // cycles held in fetch.
        stall_cnt_t  decode_stalls; // cycles held in decode.
        logic        flushed;       // flush seen while stalled in decode.
    } trace_token_t;

endpackage

// File: trace_report_pkg.sv
`include "trace_consts.svh"

package trace_report_pkg;

    import pipe_trace_pkg::*;

    typedef logic [`TRC_CYCLE_W-1:0] cycle_t;
    typedef logic [`TRC_SEQ_W-1:0]   seq_t;
    typedef logic [`TRC_TOTAL_W-1:0] total_t;

    // whole-run totals, independent of which instruction was affected.
    typedef struct packed {
        total_t pc_stall_cycles;
        total_t dec_stall_cycles;
        total_t flush_count;
    } stall_totals_t;

    // one record per retired instruction.
    // cycle is the stamp of the cycle in which the token sat in write-back.
    typedef struct packed {
        seq_t          seq;
        cycle_t        cycle;
        trace_token_t  token;
        stall_totals_t totals;      // totals snapshot at retire.
    } retire_rec_t;

endpackage

// File: instr_tracker.sv
`timescale 1ns/1ps

module instr_tracker (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        pc_stall,
    input  logic                        if_id_stall,
    input  logic                        if_flush,
    input  pipe_trace_pkg::instr_word_t instr,
    output logic                        retire_valid,
    output pipe_trace_pkg::trace_token_t retire_token
);

    import pipe_trace_pkg::*;

    // one valid bit and one token per stage from fetch through write-back.
    logic f_v;
    logic d_v;
    logic e_v;
    logic m_v;
    logic w_v;

    trace_token_t f_tok;
    trace_token_t d_tok;
    trace_token_t e_tok;
    trace_token_t m_tok;
    trace_token_t w_tok;

    logic d_move;
    logic d_free;
    logic f_move;
    logic f_free;
    logic f_load;

    trace_token_t d_leave;

    assign d_move = d_v && !if_id_stall;
    assign d_free = !d_v || d_move;           // empty now or emptying on this edge.
    assign f_move = f_v && !pc_stall && d_free;
    assign f_free = !f_v || f_move;
    assign f_load = f_free && !pc_stall && !if_id_stall;

    // the word is taken from the decode input on the edge the token leaves.
    always_comb begin
        d_leave = d_tok;
        d_leave.instr = d_tok.flushed ? '0 : instr;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            f_v <= 1'b0;
            d_v <= 1'b0;
            e_v <= 1'b0;
            m_v <= 1'b0;
            w_v <= 1'b0;
        end else begin
            w_v <= m_v;
            m_v <= e_v;
            e_v <= d_move;                    // a held decode sends a bubble.

            if (f_move) begin
                d_v <= 1'b1;
            end else if (d_move) begin
                d_v <= 1'b0;
            end

            if (f_load) begin
                f_v <= 1'b1;
            end else if (f_move) begin
                f_v <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        w_tok <= m_tok;
        m_tok <= e_tok;
        e_tok <= d_leave;

        if (f_move) begin
            d_tok <= f_tok;
        end else if (d_v && if_id_stall) begin
            if (d_tok.decode_stalls != '1) begin
                d_tok.decode_stalls <= d_tok.decode_stalls + stall_cnt_t'(1);
            end
            if (if_flush) begin
                d_tok.flushed <= 1'b1;        // sticky until the token retires.
            end
        end

        if (f_load) begin
            f_tok <= '0;                      // a fresh token has no stalls and no word yet.
        end else if (f_v && !f_move) begin
            // held by pc_stall or by a blocked decode slot.
            if (f_tok.fetch_stalls != '1) begin
                f_tok.fetch_stalls <= f_tok.fetch_stalls + stall_cnt_t'(1);
            end
        end
    end

    assign retire_valid = w_v;
    assign retire_token = w_tok;

endmodule

// File: stall_profiler.sv
`timescale 1ns/1ps

module stall_profiler (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           pc_stall,
    input  logic                           if_id_stall,
    input  logic                           if_flush,
    output trace_report_pkg::stall_totals_t totals
);

    import trace_report_pkg::*;

    // counts level cycles only, not per-instruction events.
    total_t pc_cnt;
    total_t dec_cnt;
    total_t flush_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_cnt    <= '0;
            dec_cnt   <= '0;
            flush_cnt <= '0;
        end else begin
            if (pc_stall && pc_cnt != '1) begin
                pc_cnt <= pc_cnt + total_t'(1);
            end
            if (if_id_stall && dec_cnt != '1) begin
                dec_cnt <= dec_cnt + total_t'(1);
            end
            // a flush outside a decode stall is still counted here.
            if (if_flush && flush_cnt != '1) begin
                flush_cnt <= flush_cnt + total_t'(1);
            end
        end
    end

    assign totals.pc_stall_cycles  = pc_cnt;
    assign totals.dec_stall_cycles = dec_cnt;
    assign totals.flush_count      = flush_cnt;

endmodule

// File: retire_reporter.sv
`timescale 1ns/1ps

module retire_reporter (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            retire_valid,
    input  pipe_trace_pkg::trace_token_t    retire_token,
    input  trace_report_pkg::stall_totals_t totals,
    output logic                            rec_valid,
    output trace_report_pkg::retire_rec_t   rec
);

    import trace_report_pkg::*;

    cycle_t cycle_q;  // zero in the first cycle after reset release.
    seq_t   seq_q;    // number of records issued so far.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cycle_q   <= '0;
            seq_q     <= '0;
            rec_valid <= 1'b0;
        end else begin
            cycle_q   <= cycle_q + cycle_t'(1);
            rec_valid <= retire_valid;        // one cycle after write-back.
            if (retire_valid) begin
                seq_q <= seq_q + seq_t'(1);
            end
        end
    end

    // the record holds its last value between pulses.
    always_ff @(posedge clk) begin
        if (retire_valid) begin
            rec.seq    <= seq_q;
            rec.cycle  <= cycle_q;
            rec.token  <= retire_token;
            rec.totals <= totals;
        end
    end

endmodule

// File: pipe_trace_top.sv
`timescale 1ns/1ps

module pipe_trace_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pc_stall,
    input  logic                          if_id_stall,
    input  logic                          if_flush,
    input  pipe_trace_pkg::instr_word_t   instr,
    output logic                          rec_valid,
    output trace_report_pkg::retire_rec_t rec
);

    import pipe_trace_pkg::*;
    import trace_report_pkg::*;

    logic          retire_valid;
    trace_token_t  retire_token;
    stall_totals_t totals;

    // tracker and profiler see the same strobes in the same cycle.
    instr_tracker u_tracker (
        .clk          (clk),
        .rst          (rst),
        .pc_stall     (pc_stall),
        .if_id_stall  (if_id_stall),
        .if_flush     (if_flush),
        .instr        (instr),
        .retire_valid (retire_valid),
        .retire_token (retire_token)
    );

    stall_profiler u_profiler (
        .clk         (clk),
        .rst         (rst),
        .pc_stall    (pc_stall),
        .if_id_stall (if_id_stall),
        .if_flush    (if_flush),
        .totals      (totals)
    );

    retire_reporter u_reporter (
        .clk          (clk),
        .rst          (rst),
        .retire_valid (retire_valid),
        .retire_token (retire_token),
        .totals       (totals),
        .rec_valid    (rec_valid),
        .rec          (rec)
    );

endmodule

// File: pipe_trace_props.sv
`timescale 1ns/1ps

module pipe_trace_props (
    input logic                            clk,
    input logic                            rst,
    input logic                            rec_valid,
    input trace_report_pkg::retire_rec_t   rec,
    input trace_report_pkg::stall_totals_t totals
);

    import trace_report_pkg::*;

    seq_t last_seq;   // seq of the previous record since reset.
    logic seen_rec;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_seq <= '0;
            seen_rec <= 1'b0;
        end else if (rec_valid) begin
            last_seq <= rec.seq;
            seen_rec <= 1'b1;
        end
    end

    a_quiet_reset: assert property (@(posedge clk) (rst || $past(rst)) |-> !rec_valid)
        else $error("rec_valid high during reset or in the cycle after it");

    a_seq_step: assert property (@(posedge clk) disable iff (rst)
        (rec_valid && seen_rec) |-> rec.seq == last_seq + seq_t'(1))
        else $error("rec.seq did not advance by one");

    // the run totals only ever count up or hold at saturation.
    a_totals_rise: assert property (@(posedge clk) disable iff (rst)
        totals.pc_stall_cycles  >= $past(totals.pc_stall_cycles) &&
        totals.dec_stall_cycles >= $past(totals.dec_stall_cycles) &&
        totals.flush_count      >= $past(totals.flush_count))
        else $error("a stall or flush total went down");

    a_flush_word: assert property (@(posedge clk) disable iff (rst)
        (rec_valid && rec.token.flushed) |-> rec.token.instr == '0)
        else $error("flushed record carries a nonzero instruction word");

endmodule

bind pipe_trace_top pipe_trace_props u_props (
    .clk       (clk),
    .rst       (rst),
    .rec_valid (rec_valid),
    .rec       (rec),
    .totals    (totals)
);

// File: tb_pipe_trace.sv
`timescale 1ns/1ps

module tb_pipe_trace;

    import pipe_trace_pkg::*;
    import trace_report_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int DRAIN_CYCLES = 8;
    localparam int SLACK_CYCLES = 20;

    // inputs for one cycle, as read from a C or R line.
    typedef struct packed {
        logic        rst;
        logic        pc_stall;
        logic        if_id_stall;
        logic        if_flush;
        instr_word_t instr;
    } cycle_in_t;

    logic        clk;
    logic        rst;
    logic        pc_stall;
    logic        if_id_stall;
    logic        if_flush;
    instr_word_t instr;
    logic        rec_valid;
    retire_rec_t rec;

    cycle_in_t   stim_q[$];
    retire_rec_t expect_q[$];

    int   mismatch_count;
    int   record_errors;
    int   records_seen;
    logic stim_loaded;

    pipe_trace_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .pc_stall    (pc_stall),
        .if_id_stall (if_id_stall),
        .if_flush    (if_flush),
        .instr       (instr),
        .rec_valid   (rec_valid),
        .rec         (rec)
    );

    initial begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic skip_line(input int fd);
        int ch;
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) begin
            ch = $fgetc(fd);
        end
    endtask

    task automatic load_stim(output logic ok);
        int          fd;
        int          code;
        logic [7:0]  tag;
        logic        done;
        logic [31:0] f [0:8];
        cycle_in_t   cyc;
        retire_rec_t exp_rec;
        fd = $fopen("pipe_trace_stim.txt", "r");
        ok = (fd != 0);
        done = !ok;
        while (!done) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) begin
                done = 1'b1;                  // end of file.
            end else if (tag == "#") begin
                skip_line(fd);
            end else if (tag == "R") begin
                cyc = '0;
                cyc.rst = 1'b1;
                stim_q.push_back(cyc);
            end else if (tag == "C") begin
                code = $fscanf(fd, " %h %h %h %h", f[0], f[1], f[2], f[3]);
                if (code != 4) begin
                    $display("stimulus file has a C line with missing columns");
                    ok = 1'b0;
                end
                cyc = '0;
                cyc.pc_stall    = f[0][0];
                cyc.if_id_stall = f[1][0];
                cyc.if_flush    = f[2][0];
                cyc.instr       = f[3];
                stim_q.push_back(cyc);
            end else if (tag == "E") begin
                code = $fscanf(fd, " %h %h %h %h %h %h %h %h %h",
                               f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
                if (code != 9) begin
                    $display("stimulus file has an E line with missing columns");
                    ok = 1'b0;
                end
                exp_rec = '0;
                exp_rec.seq                     = seq_t'(f[0]);
                exp_rec.cycle                   = f[1];
                exp_rec.token.instr             = f[2];
                exp_rec.token.fetch_stalls      = stall_cnt_t'(f[3]);
                exp_rec.token.decode_stalls     = stall_cnt_t'(f[4]);
                exp_rec.token.flushed           = f[5][0];
                exp_rec.totals.pc_stall_cycles  = total_t'(f[6]);
                exp_rec.totals.dec_stall_cycles = total_t'(f[7]);
                exp_rec.totals.flush_count      = total_t'(f[8]);
                expect_q.push_back(exp_rec);
            end else begin
                $display("stimulus file has a line with an unknown tag");
                ok = 1'b0;
                done = 1'b1;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endtask

    task automatic apply_cycle(input cycle_in_t c);
        rst         = c.rst;
        pc_stall    = c.pc_stall;
        if_id_stall = c.if_id_stall;
        if_flush    = c.if_flush;
        instr       = c.instr;
    endtask

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            mismatch_count++;
        end
    endtask

    // rec is registered, so it is stable at the falling edge.
    task automatic check_output();
        retire_rec_t exp_rec;
        if (rec_valid === 1'b1) begin
            records_seen++;
            if (expect_q.size() == 0) begin
                $display("a record with seq 0x%0h arrived but no record was expected", rec.seq);
                record_errors++;
            end else begin
                exp_rec = expect_q.pop_front();
                check_field("rec.seq", 64'(rec.seq), 64'(exp_rec.seq));
                check_field("rec.cycle", 64'(rec.cycle), 64'(exp_rec.cycle));
                check_field("rec.token.instr", 64'(rec.token.instr), 64'(exp_rec.token.instr));
                check_field("rec.token.fetch_stalls", 64'(rec.token.fetch_stalls),
                            64'(exp_rec.token.fetch_stalls));
                check_field("rec.token.decode_stalls", 64'(rec.token.decode_stalls),
                            64'(exp_rec.token.decode_stalls));
                check_field("rec.token.flushed", 64'(rec.token.flushed),
                            64'(exp_rec.token.flushed));
                check_field("rec.totals.pc_stall_cycles", 64'(rec.totals.pc_stall_cycles),
                            64'(exp_rec.totals.pc_stall_cycles));
                check_field("rec.totals.dec_stall_cycles", 64'(rec.totals.dec_stall_cycles),
                            64'(exp_rec.totals.dec_stall_cycles));
                check_field("rec.totals.flush_count", 64'(rec.totals.flush_count),
                            64'(exp_rec.totals.flush_count));
            end
        end
    endtask

    initial begin : main_seq
        logic      ok;
        cycle_in_t idle;
        rst            = 1'b1;
        pc_stall       = 1'b0;
        if_id_stall    = 1'b0;
        if_flush       = 1'b0;
        instr          = '0;
        mismatch_count = 0;
        record_errors  = 0;
        records_seen   = 0;
        stim_loaded    = 1'b0;
        load_stim(ok);
        stim_loaded = 1'b1;
        if (!ok) begin
            $display("could not read the stimulus from pipe_trace_stim.txt");
            record_errors++;
        end else begin
            repeat (RESET_CYCLES) @(posedge clk);
            foreach (stim_q[i]) begin
                @(negedge clk);
                check_output();
                apply_cycle(stim_q[i]);
            end
            idle = '0;
            idle.pc_stall = 1'b1;             // keeps new tokens out while the pipe drains.
            repeat (DRAIN_CYCLES) begin
                @(negedge clk);
                check_output();
                apply_cycle(idle);
            end
            if (expect_q.size() != 0) begin
                $display("%0d expected records never arrived", expect_q.size());
                record_errors += expect_q.size();
            end
        end
        $display("records seen %0d, field mismatches %0d, record errors %0d",
                 records_seen, mismatch_count, record_errors);
        if (mismatch_count == 0 && record_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // the run needs reset, one cycle per stimulus line and a short drain.
    initial begin : watchdog
        int limit_ns;
        wait (stim_loaded === 1'b1);
        limit_ns = (stim_q.size() + SLACK_CYCLES) * CLK_PERIOD;
        #(limit_ns);
        $display("timeout: the run did not finish within %0d ns", limit_ns);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: pipe_trace_stim.txt
# C pc_stall if_id_stall if_flush instr : one cycle of inputs, R : one cycle with reset held
# E seq cycle instr fetch_stalls decode_stalls flushed pc_total dec_total flush_total (hex)
# unstalled start, then a two-cycle pc_stall
C 0 0 0 10000000
C 0 0 0 10000001
C 0 0 0 10000002
C 1 0 0 10000003
C 1 0 0 10000004
C 0 0 0 10000005
C 0 0 0 10000006
# three-cycle decode stall with a flush in its middle
C 0 1 0 10000007
C 0 1 1 10000008
C 0 1 0 10000009
C 0 0 0 1000000a
C 0 0 0 1000000b
# one-cycle decode stall, then fetch held
C 0 1 0 1000000c
C 0 0 0 1000000d
C 1 0 0 1000000e
C 1 0 0 1000000f
C 1 0 0 10000010
E 0 5 10000002 0 0 0 2 0 0
E 1 6 10000003 0 0 0 2 0 0
E 2 9 10000006 2 0 0 2 2 1
E 3 d 00000000 0 3 1 2 4 1
E 4 e 1000000b 3 0 0 2 4 1
E 5 10 1000000d 0 1 0 4 4 1
# reset with two tokens still in flight
R
R
C 0 0 0 20000000
C 0 0 0 20000001
C 0 0 0 20000002
C 1 0 0 20000003
C 1 0 0 20000004
C 1 0 0 20000005
C 1 0 0 20000006
C 1 0 0 20000007
E 0 5 20000002 0 0 0 2 0 0
E 1 6 20000003 0 0 0 3 0 0

// File: tb.f
+incdir+.
pipe_trace_pkg.sv
trace_report_pkg.sv
instr_tracker.sv
stall_profiler.sv
retire_reporter.sv
pipe_trace_top.sv
pipe_trace_props.sv
tb_pipe_trace.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_pipe_trace
FILELIST  := tb.f
BUILD_DIR := obj_dir
PASS_MSG  := TEST PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
